// ==== Makefile ====
# Verilator build and run of the fabric testbench
# override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_soc_fabric
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) into $(LOG) and check the log"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "test FAILED, see $(LOG)"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "test FAILED, no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
+incdir+test
verilog/soc_bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/soc_reset_ctrl.sv
verilog/pi1_router.sv
verilog/dev_table.sv
verilog/int_ctrl.sv
verilog/scratch_ram.sv
verilog/soc_fabric_top.sv
test/tb_soc_fabric.sv

// ==== test/tb_soc_fabric_tasks.svh ====
// PI1 master tasks and the RAM reference model, included inside the testbench module
// each request task returns on the edge that accepts it, so calls may run back to back

	word_t ram_model [RAM_WORDS];
	word_t exp_data_q [$];
	string exp_name_q [$];

	// bytes with a select bit take the new value
	function automatic word_t merge_lanes(input word_t old_w, input word_t new_w,
		input sel_t sel);
		word_t res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[b*8 +: 8] = new_w[b*8 +: 8];
			end
		end
		return res;
	endfunction

	// the falling edge checker pops one entry in the cycle after acceptance
	function automatic void expect_data(input word_t exp, input string name);
		exp_data_q.push_back(exp);
		exp_name_q.push_back(name);
	endfunction

	// starts on a rising edge and holds the request until the fabric is ready
	task automatic bus_request(input pi1_op_t op, input addr_t addr, input word_t data,
		input sel_t sel);
		pi1_op_i   <= op;
		pi1_addr_i <= addr;
		pi1_data_i <= data;
		pi1_sel_i  <= sel;
		@(negedge clk120mhz);
		while (!pi1_rdy_o) begin
			@(negedge clk120mhz);
		end
		@(posedge clk120mhz);
	endtask

	task automatic bus_idle();
		pi1_op_i <= PI1_NONE;
		@(posedge clk120mhz);
	endtask

	task automatic bus_read(input addr_t addr, input word_t exp, input string name);
		bus_request(PI1_READ, addr, '0, 4'hF);
		expect_data(exp, name);
	endtask

	task automatic bus_write(input addr_t addr, input word_t data);
		bus_request(PI1_WRITE, addr, data, 4'hF);
	endtask

	// RAM word idx sits at word address idx, the RAM slot starts at 0
	task automatic ram_access(input pi1_op_t op, input int unsigned idx, input word_t data,
		input sel_t sel);
		bus_request(op, addr_t'(idx), data, sel);
		if (op != PI1_WRITE) begin
			expect_data(ram_model[idx], (op == PI1_SWAP) ? "ram swap" : "ram read");
		end
		if (op != PI1_READ) begin
			ram_model[idx] = merge_lanes(ram_model[idx], data, sel);
		end
	endtask

// ==== test/tb_soc_fabric.sv ====
// testbench for soc_fabric_top as PI1 master, interrupt sources and interrupt destination
// inputs change at the rising edge, outputs are checked at the falling edge
// RAM checks only touch RAM_SPAN words that are fully written first
`timescale 1ns/1ps
`default_nettype none

module tb_soc_fabric
	import soc_bus_pkg::*;
();

	localparam int RAM_WORDS     = 1024;
	localparam int INT_SRC_COUNT = 2;
	localparam int CLK_PERIOD    = 20;
	localparam int RST_CYCLES    = 8;
	localparam int RST_STRETCH   = 15;
	localparam int RAM_SPAN      = 16;
	localparam int RAM_OPS       = 64;
	// cycles per test: two resets, RAM, map, interrupts, warm reset, power-off
	localparam int TEST_CYCLES = 2 * (RST_CYCLES + RST_STRETCH + 4) + 3 * RAM_SPAN
		+ 2 * RAM_OPS + 30 + 60 + 50 + 60;
	localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;
	localparam addr_t DEVTBL_W  = 30'h400;
	localparam addr_t INTC_W    = 30'h410;
	localparam addr_t INVALID_W = 30'h414;
	localparam addr_t FAR_W     = 30'h800;

	logic                     clk120mhz = 1'b0;
	logic                     rst_p;
	pi1_op_t                  pi1_op_i;
	addr_t                    pi1_addr_i;
	word_t                    pi1_data_i;
	sel_t                     pi1_sel_i;
	logic [INT_SRC_COUNT-1:0] intrqst_src_i;
	logic                     intrdy_i;
	word_t                    pi1_data_o;
	logic                     pi1_rdy_o;
	logic [INT_SRC_COUNT-1:0] intrdy_src_o;
	logic                     intrqst_o;
	logic                     sys_rst_o;
	integer                   seed;
	string                    test_name;
	logic                     src1_masked;
	logic                     powered_off;

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "stopped at the first error");
	endtask

	`include "tb_soc_fabric_tasks.svh"

	soc_fabric_top #(
		.RAM_WORDS     (RAM_WORDS),
		.INT_SRC_COUNT (INT_SRC_COUNT),
		.RST_CNT_BITS  (4)
	) u_dut (
		.clk120mhz     (clk120mhz),
		.rst_p         (rst_p),
		.pi1_op_i      (pi1_op_i),
		.pi1_addr_i    (pi1_addr_i),
		.pi1_data_i    (pi1_data_i),
		.pi1_sel_i     (pi1_sel_i),
		.intrqst_src_i (intrqst_src_i),
		.intrdy_i      (intrdy_i),
		.pi1_data_o    (pi1_data_o),
		.pi1_rdy_o     (pi1_rdy_o),
		.intrdy_src_o  (intrdy_src_o),
		.intrqst_o     (intrqst_o),
		.sys_rst_o     (sys_rst_o)
	);

	always #(CLK_PERIOD / 2) clk120mhz = ~clk120mhz;

	a_rdy_in_reset: assert property (@(posedge clk120mhz) disable iff (rst_p)
		pi1_rdy_o == !sys_rst_o)
		else fail_now("bus ready did not follow the system reset");
	a_quiet_in_reset: assert property (@(posedge clk120mhz) disable iff (rst_p)
		$past(sys_rst_o) |-> !intrqst_o && intrdy_src_o == '0)
		else fail_now("interrupt outputs were active during system reset");
	a_ack_pulse: assert property (@(posedge clk120mhz) disable iff (rst_p)
		intrdy_src_o != '0 |=> intrdy_src_o == '0)
		else fail_now("a source acknowledge lasted more than one cycle");
	a_masked_quiet: assert property (@(posedge clk120mhz)
		src1_masked |-> !intrqst_o && !intrdy_src_o[1])
		else fail_now("the masked interrupt source was delivered");
	a_powered_off: assert property (@(posedge clk120mhz)
		powered_off |-> sys_rst_o && !pi1_rdy_o)
		else fail_now("the fabric left reset while powered off");

	// read data is valid only in the cycle after acceptance
	always @(negedge clk120mhz) begin
		word_t exp;
		string name;
		if (exp_data_q.size() > 0) begin
			exp  = exp_data_q.pop_front();
			name = exp_name_q.pop_front();
			assert (pi1_data_o === exp)
				else fail_now($sformatf("Error: %s expected %h actual %h", name, exp, pi1_data_o));
		end
	end

	// spread the tested words over the whole RAM
	function automatic int unsigned span_index(input int i);
		return (i * 67) % RAM_WORDS;
	endfunction

	function automatic int unsigned random_index();
		return span_index(int'($unsigned($random(seed)) % RAM_SPAN));
	endfunction

	// device table word w, slot order RAM, device table, interrupt controller, invalid
	function automatic word_t map_word(input int w);
		case (w)
			0: return 32'd4;
			2: return word_t'(RAM_WORDS * 4);
			3: return 32'd1;
			4: return 32'd64;
			5: return 32'd7;
			6: return 32'd16;
			7: return 32'd3;
			8: return 32'd4096;
			default: return 32'd0;
		endcase
	endfunction

	task automatic count_reset_cycles(output int high_cycles);
		high_cycles = 0;
		@(negedge clk120mhz);
		while (sys_rst_o && high_cycles < 40) begin
			high_cycles++;
			@(negedge clk120mhz);
		end
	endtask

	task automatic reset_and_check();
		int high_cycles;
		test_name = "reset";
		rst_p       <= 1'b1;
		powered_off <= 1'b0;
		repeat (RST_CYCLES) @(posedge clk120mhz);
		rst_p <= 1'b0;
		count_reset_cycles(high_cycles);
		assert (high_cycles == RST_STRETCH)
			else fail_now($sformatf("Error: %s expected %0d actual %0d", test_name,
				RST_STRETCH, high_cycles));
		@(posedge clk120mhz);
	endtask

	task automatic run_ram_test();
		int unsigned idx;
		for (int i = 0; i < RAM_SPAN; i++) begin
			ram_access(PI1_WRITE, span_index(i), word_t'($random(seed)), 4'hF);
		end
		for (int i = 0; i < RAM_OPS; i++) begin
			ram_access(PI1_WRITE, random_index(), word_t'($random(seed)),
				sel_t'($random(seed)));
		end
		for (int i = 0; i < RAM_SPAN; i++) begin
			ram_access(PI1_READ, span_index(i), '0, '0);
		end
		for (int i = 0; i < RAM_OPS / 2; i++) begin
			idx = random_index();
			ram_access(PI1_SWAP, idx, word_t'($random(seed)), sel_t'($random(seed)));
			ram_access(PI1_READ, idx, '0, '0);
		end
		bus_idle();
		ram_access(PI1_READ, span_index(1), '0, '0);
		bus_idle();
	endtask

	task automatic run_map_test();
		bus_read(DEVTBL_W, map_word(0), "map word 0");
		for (int w = 2; w < 10; w++) begin
			bus_read(addr_t'(DEVTBL_W + w), map_word(w), $sformatf("map word %0d", w));
		end
		// unmapped words read zero, and the far write must not reach RAM word 0
		bus_write(INVALID_W, word_t'($random(seed)));
		bus_write(FAR_W, word_t'($random(seed)));
		bus_read(INVALID_W, 32'd0, "invalid read");
		bus_read(FAR_W, 32'd0, "invalid read");
		ram_access(PI1_READ, 0, '0, '0);
		bus_idle();
	endtask

	// the testbench acts as the interrupt destination
	task automatic serve_interrupt(input int src);
		int waited;
		logic [INT_SRC_COUNT-1:0] exp_ack;
		waited  = 0;
		exp_ack = '0;
		exp_ack[src] = 1'b1;
		@(negedge clk120mhz);
		while (!intrqst_o && waited < 10) begin
			waited++;
			@(negedge clk120mhz);
		end
		assert (intrqst_o) else fail_now("no interrupt request reached the destination");
		@(posedge clk120mhz);
		intrdy_i <= 1'b1;
		@(posedge clk120mhz);
		intrdy_i <= 1'b0;
		@(negedge clk120mhz);
		assert (intrdy_src_o == exp_ack)
			else fail_now($sformatf("Error: interrupt ack expected %b actual %b", exp_ack,
				intrdy_src_o));
		@(posedge clk120mhz);
		intrqst_src_i[src] <= 1'b0;
	endtask

	task automatic run_int_test();
		intrqst_src_i <= 2'b11;
		@(posedge clk120mhz);
		for (int k = 0; k < INT_SRC_COUNT; k++) begin
			serve_interrupt(k);
			bus_read(INTC_W, word_t'(k), "interrupt last source");
			bus_idle();
		end
		bus_write(INTC_W + 30'd1, 32'h1);
		bus_idle();
		src1_masked      <= 1'b1;
		intrqst_src_i[1] <= 1'b1;
		repeat (20) @(posedge clk120mhz);
		intrqst_src_i[1] <= 1'b0;
		@(posedge clk120mhz);
		src1_masked <= 1'b0;
	endtask

	task automatic run_soft_reset_test();
		int rise_wait;
		int high_cycles;
		// warm reset is rst1 alone
		bus_write(DEVTBL_W + 30'd1, 32'h2);
		pi1_op_i  <= PI1_NONE;
		rise_wait = 0;
		@(negedge clk120mhz);
		while (!sys_rst_o && rise_wait < 5) begin
			rise_wait++;
			@(negedge clk120mhz);
		end
		assert (rise_wait <= 2)
			else fail_now($sformatf("Error: warm reset rise expected at most 2 actual %0d",
				rise_wait));
		count_reset_cycles(high_cycles);
		assert (high_cycles + 1 >= RST_STRETCH && high_cycles + 1 <= RST_STRETCH + 2)
			else fail_now($sformatf("Error: warm reset expected 15 to 17 actual %0d",
				high_cycles + 1));
		@(posedge clk120mhz);
		for (int i = 0; i < RAM_SPAN; i++) begin
			ram_access(PI1_READ, span_index(i), '0, '0);
		end
		bus_read(DEVTBL_W + 30'd1, 32'd0, "reset control after warm reset");
		// power-off is rst0 alone and holds until rst_p
		bus_write(DEVTBL_W + 30'd1, 32'h1);
		pi1_op_i <= PI1_NONE;
		repeat (2) @(posedge clk120mhz);
		powered_off <= 1'b1;
		// sources raised while powered off must stay unanswered
		intrqst_src_i <= '1;
		repeat (40) @(posedge clk120mhz);
		intrqst_src_i <= '0;
		reset_and_check();
		ram_access(PI1_READ, span_index(2), '0, '0);
		bus_idle();
	endtask

	initial begin
		seed          = 32'he61e2edd;
		src1_masked   = 1'b0;
		powered_off   = 1'b0;
		rst_p         <= 1'b1;
		pi1_op_i      <= PI1_NONE;
		pi1_addr_i    <= '0;
		pi1_data_i    <= '0;
		pi1_sel_i     <= '0;
		intrqst_src_i <= '0;
		intrdy_i      <= 1'b0;
		reset_and_check();
		test_name = "ram";
		run_ram_test();
		run_map_test();
		run_int_test();
		run_soft_reset_test();
		repeat (2) @(posedge clk120mhz);
		if (exp_data_q.size() != 0) begin
			fail_now("some read data was never checked");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		fail_now("watchdog timeout, the tests did not finish in time");
	end

endmodule

`default_nettype wire

// ==== verilog/dev_table.sv ====
// device table: slot count, per-slot map size and id, software reset control
// control word bit 0 is rst0, bit 1 is rst1, both cleared by the system reset
`timescale 1ns/1ps
`default_nettype none

module dev_table
	import soc_bus_pkg::*;
	import soc_map_pkg::*;
#(
	parameter int RAM_WORDS = 1024
) (
	input  wire          clk120mhz,
	input  wire          sys_rst_i,
	input  wire          req_i,
	input  wire pi1_op_t op_i,
	input  wire addr_t   addr_i,
	input  wire word_t   data_i,
	input  wire sel_t    sel_i,
	output word_t        data_o,
	output logic         rst0_o,
	output logic         rst1_o
);

	localparam int WIDX_BITS = $clog2(DEVTBL_MAPSZ / (ARCH_BITS / 8));

	word_t                slot_mapsz [SLOT_COUNT];
	word_t                slot_id    [SLOT_COUNT];
	logic                 slot_intr  [SLOT_COUNT];
	logic [WIDX_BITS-1:0] widx;
	slot_t                slot;
	word_t                rd_word;
	logic                 wr;

	assign slot_mapsz[SLOT_RAM]     = word_t'(ram_mapsz(RAM_WORDS));
	assign slot_mapsz[SLOT_DEVTBL]  = word_t'(DEVTBL_MAPSZ);
	assign slot_mapsz[SLOT_INTCTRL] = word_t'(INTCTRL_MAPSZ);
	assign slot_mapsz[SLOT_INVALID] = word_t'(INVALID_MAPSZ);
	assign slot_id[SLOT_RAM]        = word_t'(ID_RAM);
	assign slot_id[SLOT_DEVTBL]     = word_t'(ID_DEVTBL);
	assign slot_id[SLOT_INTCTRL]    = word_t'(ID_INTCTRL);
	assign slot_id[SLOT_INVALID]    = word_t'(ID_INVALID);
	assign slot_intr[SLOT_RAM]      = USEINTR_RAM;
	assign slot_intr[SLOT_DEVTBL]   = USEINTR_DEVTBL;
	assign slot_intr[SLOT_INTCTRL]  = USEINTR_INTCTRL;
	assign slot_intr[SLOT_INVALID]  = USEINTR_INVALID;

	assign widx = addr_i[WIDX_BITS-1:0];
	assign slot = slot_t'((widx - 2'd2) >> 1);
	assign wr   = req_i && (op_i == PI1_WRITE || op_i == PI1_SWAP);

	// word 2+2k holds size and flag of slot k, word 3+2k its id
	always_comb begin
		rd_word = '0;
		if (widx == 0) begin
			rd_word = word_t'(SLOT_COUNT);
		end else if (widx == 1) begin
			rd_word = {{(ARCH_BITS-2){1'b0}}, rst1_o, rst0_o};
		end else if (widx < 2 + 2 * SLOT_COUNT) begin
			if (widx[0]) begin
				rd_word = slot_id[slot];
			end else begin
				rd_word = slot_mapsz[slot] | word_t'(slot_intr[slot]);
			end
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (req_i) begin
			data_o <= rd_word;
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
		end else if (wr && widx == 1 && sel_i[0]) begin
			rst0_o <= data_i[0];
			rst1_o <= data_i[1];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/int_ctrl.sv ====
// interrupt controller with one destination, lowest enabled source index wins
// a source holds its request until its intrdy_src_o pulse; INT_SRC_COUNT is at most 32
`timescale 1ns/1ps
`default_nettype none

module int_ctrl
	import soc_bus_pkg::*;
#(
	parameter int INT_SRC_COUNT = 2
) (
	input  wire                      clk120mhz,
	input  wire                      sys_rst_i,
	input  wire                      req_i,
	input  wire pi1_op_t             op_i,
	input  wire addr_t               addr_i,
	input  wire word_t               data_i,
	input  wire sel_t                sel_i,
	input  wire [INT_SRC_COUNT-1:0]  intrqst_src_i,
	input  wire                      intrdy_i,
	output word_t                    data_o,
	output logic                     intrqst_o,
	output logic [INT_SRC_COUNT-1:0] intrdy_src_o
);

	localparam int IDX_BITS = (INT_SRC_COUNT > 1) ? $clog2(INT_SRC_COUNT) : 1;

	typedef enum logic [1:0] {IDLE, DELIVER, ACK} state_t;

	state_t                   state_q;
	logic [IDX_BITS-1:0]      cur_q;
	logic [IDX_BITS-1:0]      last_q;
	logic [IDX_BITS-1:0]      next_idx;
	logic [INT_SRC_COUNT-1:0] mask_q;
	logic [INT_SRC_COUNT-1:0] pending;
	logic                     found;
	logic                     wr;

	assign pending = intrqst_src_i & mask_q;
	assign wr      = req_i && (op_i == PI1_WRITE || op_i == PI1_SWAP);

	// scan from the top so the lowest pending index is kept
	always_comb begin
		next_idx = '0;
		found    = 1'b0;
		for (int k = INT_SRC_COUNT - 1; k >= 0; k--) begin
			if (pending[k]) begin
				next_idx = IDX_BITS'(k);
				found    = 1'b1;
			end
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			state_q <= IDLE;
			last_q  <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (found) begin
						state_q <= DELIVER;
					end
				end
				DELIVER: begin
					if (intrdy_i) begin
						last_q  <= cur_q;
						state_q <= ACK;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// source being delivered, captured while idle
	always_ff @(posedge clk120mhz) begin
		if (state_q == IDLE && found) begin
			cur_q <= next_idx;
		end
	end

	// mask write honours the byte lanes
	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			mask_q <= '1;
		end else if (wr && addr_i[1:0] == 2'd1) begin
			for (int b = 0; b < INT_SRC_COUNT; b++) begin
				if (sel_i[b / 8]) begin
					mask_q[b] <= data_i[b];
				end
			end
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (req_i) begin
			case (addr_i[1:0])
				2'd0:    data_o <= word_t'(last_q);
				2'd1:    data_o <= word_t'(mask_q);
				default: data_o <= '0;
			endcase
		end
	end

	assign intrqst_o = (state_q == DELIVER);

	always_comb begin
		for (int k = 0; k < INT_SRC_COUNT; k++) begin
			intrdy_src_o[k] = (state_q == ACK) && (cur_q == IDX_BITS'(k));
		end
	end

	a_rqst_held: assert property (@(posedge clk120mhz) disable iff (sys_rst_i)
		intrqst_o && !intrdy_i |=> intrqst_o);

endmodule

`default_nettype wire

// ==== verilog/pi1_router.sv ====
// PI1 router for one master and the slots of soc_map_pkg
// slaves answer one cycle after their strobe; the invalid slot reads zero and drops writes
// RAM_WORDS must fit below the device table base
`timescale 1ns/1ps
`default_nettype none

module pi1_router
	import soc_bus_pkg::*;
	import soc_map_pkg::*;
#(
	parameter int RAM_WORDS = 1024
) (
	input  wire                    clk120mhz,
	input  wire                    sys_rst_i,
	input  wire pi1_op_t           pi1_op_i,
	input  wire addr_t             pi1_addr_i,
	input  wire word_t             pi1_data_i,
	input  wire sel_t              pi1_sel_i,
	input  wire word_t             ram_data_i,
	input  wire word_t             devtbl_data_i,
	input  wire word_t             intctrl_data_i,
	output word_t                  pi1_data_o,
	output logic                   pi1_rdy_o,
	output logic [SLOT_COUNT-1:0]  slave_req_o,
	output pi1_op_t                slave_op_o,
	output addr_t                  slave_addr_o,
	output word_t                  slave_data_o,
	output sel_t                   slave_sel_o
);

	localparam int WSH = $clog2(ARCH_BITS / 8);

	// word address windows, upper bound exclusive
	localparam addr_t RAM_LO     = addr_t'(RAM_BASE >> WSH);
	localparam addr_t RAM_HI     = addr_t'((RAM_BASE >> WSH) + RAM_WORDS);
	localparam addr_t DEVTBL_LO  = addr_t'(DEVTBL_BASE >> WSH);
	localparam addr_t DEVTBL_HI  = addr_t'((DEVTBL_BASE + DEVTBL_MAPSZ) >> WSH);
	localparam addr_t INTCTRL_LO = addr_t'(INTCTRL_BASE >> WSH);
	localparam addr_t INTCTRL_HI = addr_t'((INTCTRL_BASE + INTCTRL_MAPSZ) >> WSH);

	slot_t slot;
	slot_t slot_q;
	addr_t base;
	logic  accept;

	always_comb begin
		slot = slot_t'(SLOT_INVALID);
		base = '0;
		if (pi1_addr_i >= RAM_LO && pi1_addr_i < RAM_HI) begin
			slot = slot_t'(SLOT_RAM);
			base = RAM_LO;
		end else if (pi1_addr_i >= DEVTBL_LO && pi1_addr_i < DEVTBL_HI) begin
			slot = slot_t'(SLOT_DEVTBL);
			base = DEVTBL_LO;
		end else if (pi1_addr_i >= INTCTRL_LO && pi1_addr_i < INTCTRL_HI) begin
			slot = slot_t'(SLOT_INTCTRL);
			base = INTCTRL_LO;
		end
	end

	// every slave is always ready, so only reset holds the master off
	assign pi1_rdy_o = !sys_rst_i;
	assign accept    = (pi1_op_i != PI1_NONE) && pi1_rdy_o;

	always_comb begin
		for (int k = 0; k < SLOT_COUNT; k++) begin
			slave_req_o[k] = accept && (slot == slot_t'(k));
		end
	end

	assign slave_op_o   = pi1_op_i;
	assign slave_addr_o = pi1_addr_i - base;
	assign slave_data_o = pi1_data_i;
	assign slave_sel_o  = pi1_sel_i;

	// remember who owns the data phase of the next cycle
	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			slot_q <= slot_t'(SLOT_INVALID);
		end else if (accept) begin
			slot_q <= slot;
		end
	end

	always_comb begin
		case (slot_q)
			slot_t'(SLOT_RAM):     pi1_data_o = ram_data_i;
			slot_t'(SLOT_DEVTBL):  pi1_data_o = devtbl_data_i;
			slot_t'(SLOT_INTCTRL): pi1_data_o = intctrl_data_i;
			default:               pi1_data_o = '0;
		endcase
	end

	a_one_slave: assert property (@(posedge clk120mhz) disable iff (sys_rst_i)
		$onehot0(slave_req_o));

endmodule

`default_nettype wire

// ==== verilog/scratch_ram.sv ====
// single port word RAM, one cycle read latency, contents survive reset
// RAM_WORDS is a power of two; address bits above the RAM index are ignored
`timescale 1ns/1ps
`default_nettype none

module scratch_ram
	import soc_bus_pkg::*;
#(
	parameter int RAM_WORDS = 1024
) (
	input  wire          clk120mhz,
	input  wire          req_i,
	input  wire pi1_op_t op_i,
	input  wire addr_t   addr_i,
	input  wire word_t   data_i,
	input  wire sel_t    sel_i,
	output word_t        data_o
);

	localparam int IDX_BITS = $clog2(RAM_WORDS);

	word_t                mem [RAM_WORDS];
	logic [IDX_BITS-1:0]  idx;
	logic                 wr;

	assign idx = addr_i[IDX_BITS-1:0];
	assign wr  = req_i && (op_i == PI1_WRITE || op_i == PI1_SWAP);

	// read before write, so a swap hands back the old word
	always_ff @(posedge clk120mhz) begin
		if (req_i) begin
			data_o <= mem[idx];
		end
		if (wr) begin
			for (int b = 0; b < ARCH_BITS / 8; b++) begin
				if (sel_i[b]) begin
					mem[idx][b*8 +: 8] <= data_i[b*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/soc_bus_pkg.sv ====
// PI1 bus definitions shared by the master side and every slave
// a word address counts ARCH_BITS/8 byte units, byte selects pick lanes
`default_nettype none

package soc_bus_pkg;

	localparam int ARCH_BITS = 32;
	// byte offset bits dropped from a byte address
	localparam int ADDR_BITS = ARCH_BITS - $clog2(ARCH_BITS / 8);

	typedef logic [ARCH_BITS-1:0] word_t;
	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [(ARCH_BITS/8)-1:0] sel_t;

	// bus operation
	typedef logic [1:0] pi1_op_t;

	localparam pi1_op_t PI1_NONE  = 2'd0;
	localparam pi1_op_t PI1_WRITE = 2'd1;
	localparam pi1_op_t PI1_READ  = 2'd2;
	// swap returns the old word and stores the new one
	localparam pi1_op_t PI1_SWAP  = 2'd3;

endpackage

`default_nettype wire

// ==== verilog/soc_fabric_top.sv ====
// fabric top: reset controller, PI1 router and the three slaves on clk120mhz
// rst_p is synchronous; pi1_rdy_o stays low while sys_rst_o is high
`timescale 1ns/1ps
`default_nettype none

module soc_fabric_top
	import soc_bus_pkg::*;
	import soc_map_pkg::*;
#(
	parameter int RAM_WORDS     = 1024,
	parameter int INT_SRC_COUNT = 2,
	parameter int RST_CNT_BITS  = 4
) (
	input  wire                      clk120mhz,
	input  wire                      rst_p,
	input  wire pi1_op_t             pi1_op_i,
	input  wire addr_t               pi1_addr_i,
	input  wire word_t               pi1_data_i,
	input  wire sel_t                pi1_sel_i,
	input  wire [INT_SRC_COUNT-1:0]  intrqst_src_i,
	input  wire                      intrdy_i,
	output word_t                    pi1_data_o,
	output logic                     pi1_rdy_o,
	output logic [INT_SRC_COUNT-1:0] intrdy_src_o,
	output logic                     intrqst_o,
	output logic                     sys_rst_o
);

	logic                  rst0;
	logic                  rst1;
	logic [SLOT_COUNT-1:0] slave_req;
	pi1_op_t               slave_op;
	addr_t                 slave_addr;
	word_t                 slave_data;
	sel_t                  slave_sel;
	word_t                 ram_rdata;
	word_t                 devtbl_rdata;
	word_t                 intctrl_rdata;

	soc_reset_ctrl #(.RST_CNT_BITS(RST_CNT_BITS)) u_reset_ctrl (
		.clk120mhz (clk120mhz),
		.rst_p     (rst_p),
		.rst0_i    (rst0),
		.rst1_i    (rst1),
		.sys_rst_o (sys_rst_o)
	);

	pi1_router #(.RAM_WORDS(RAM_WORDS)) u_router (
		.clk120mhz      (clk120mhz),
		.sys_rst_i      (sys_rst_o),
		.pi1_op_i       (pi1_op_i),
		.pi1_addr_i     (pi1_addr_i),
		.pi1_data_i     (pi1_data_i),
		.pi1_sel_i      (pi1_sel_i),
		.ram_data_i     (ram_rdata),
		.devtbl_data_i  (devtbl_rdata),
		.intctrl_data_i (intctrl_rdata),
		.pi1_data_o     (pi1_data_o),
		.pi1_rdy_o      (pi1_rdy_o),
		.slave_req_o    (slave_req),
		.slave_op_o     (slave_op),
		.slave_addr_o   (slave_addr),
		.slave_data_o   (slave_data),
		.slave_sel_o    (slave_sel)
	);

	// RAM is left out of the system reset
	scratch_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
		.clk120mhz (clk120mhz),
		.req_i     (slave_req[SLOT_RAM]),
		.op_i      (slave_op),
		.addr_i    (slave_addr),
		.data_i    (slave_data),
		.sel_i     (slave_sel),
		.data_o    (ram_rdata)
	);

	dev_table #(.RAM_WORDS(RAM_WORDS)) u_dev_table (
		.clk120mhz (clk120mhz),
		.sys_rst_i (sys_rst_o),
		.req_i     (slave_req[SLOT_DEVTBL]),
		.op_i      (slave_op),
		.addr_i    (slave_addr),
		.data_i    (slave_data),
		.sel_i     (slave_sel),
		.data_o    (devtbl_rdata),
		.rst0_o    (rst0),
		.rst1_o    (rst1)
	);

	int_ctrl #(.INT_SRC_COUNT(INT_SRC_COUNT)) u_int_ctrl (
		.clk120mhz     (clk120mhz),
		.sys_rst_i     (sys_rst_o),
		.req_i         (slave_req[SLOT_INTCTRL]),
		.op_i          (slave_op),
		.addr_i        (slave_addr),
		.data_i        (slave_data),
		.sel_i         (slave_sel),
		.intrqst_src_i (intrqst_src_i),
		.intrdy_i      (intrdy_i),
		.data_o        (intctrl_rdata),
		.intrqst_o     (intrqst_o),
		.intrdy_src_o  (intrdy_src_o)
	);

endmodule

`default_nettype wire

// ==== verilog/soc_map_pkg.sv ====
// address map of the fabric, byte based
// map sizes are powers of two of at least 16, so bit 0 carries the interrupt-use flag
// the RAM slot starts at 0 and must not reach past the device table base
`default_nettype none

package soc_map_pkg;

	// slot indices, the last one catches unmapped addresses
	localparam int SLOT_RAM     = 0;
	localparam int SLOT_DEVTBL  = 1;
	localparam int SLOT_INTCTRL = 2;
	localparam int SLOT_INVALID = 3;
	localparam int SLOT_COUNT   = 4;

	typedef logic [1:0] slot_t;

	// byte base addresses
	localparam int unsigned RAM_BASE     = 'h0000;
	localparam int unsigned DEVTBL_BASE  = 'h1000;
	localparam int unsigned INTCTRL_BASE = 'h1040;

	// byte map sizes
	localparam int unsigned DEVTBL_MAPSZ  = 64;
	localparam int unsigned INTCTRL_MAPSZ = 16;
	localparam int unsigned INVALID_MAPSZ = 'h1000;

	// RAM size follows the word count, 4096 bytes for 1024 words
	function automatic int unsigned ram_mapsz(input int unsigned ram_words);
		return ram_words * 4;
	endfunction

	// device ids as seen by software
	localparam int unsigned ID_RAM     = 1;
	localparam int unsigned ID_DEVTBL  = 7;
	localparam int unsigned ID_INTCTRL = 3;
	localparam int unsigned ID_INVALID = 0;

	// no slot raises interrupts through the controller itself
	localparam bit USEINTR_RAM     = 1'b0;
	localparam bit USEINTR_DEVTBL  = 1'b0;
	localparam bit USEINTR_INTCTRL = 1'b0;
	localparam bit USEINTR_INVALID = 1'b0;

endpackage

`default_nettype wire

// ==== verilog/soc_reset_ctrl.sv ====
// reset stretcher: sys_rst_o is high for 2**RST_CNT_BITS-1 cycles after rst_p or warm reset
// power-off holds the reset until the next rst_p; a cold reset request is ignored
`timescale 1ns/1ps
`default_nettype none

module soc_reset_ctrl #(
	parameter int RST_CNT_BITS = 4
) (
	input  wire  clk120mhz,
	input  wire  rst_p,
	input  wire  rst0_i,
	input  wire  rst1_i,
	output logic sys_rst_o
);

	logic [RST_CNT_BITS-1:0] cnt_q;
	logic                    pwroff_q;
	logic                    sw_warm;
	logic                    sw_pwroff;

	// rst1 alone asks for warm reset, rst0 alone for power-off, both together is cold
	assign sw_warm   = rst1_i && !rst0_i;
	assign sw_pwroff = rst0_i && !rst1_i;

	always_ff @(posedge clk120mhz) begin
		if (rst_p || sw_warm) begin
			cnt_q <= '1;
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// only an external reset brings the system back from power-off
	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = pwroff_q || (cnt_q != '0);

	// the device table drops its control bits under the reset they caused
	a_ctrl_cleared: assert property (@(posedge clk120mhz)
		sys_rst_o |=> !rst0_i && !rst1_i);

endmodule

`default_nettype wire
